/* design/rhPkg.sv */
////////////////////////////////////////////////////////////////////////////
// RH11 transfer-address types and CS1 bit positions
// Data bus is little-endian here; only GO and BAE of CS1 are given fields
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package rhPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////////////////////////////////////////

   // Device data word from the KS10 I/O bus
   // Bit 0 is the least significant bit
   typedef logic [35:0] rhData_t;

   // Unibus byte address in BA
   // Bits 17:16 are the extension from CS1
   typedef logic [17:0] rhAddr_t;

   // Word count, two's complement
   // Counts up toward zero
   typedef logic [15:0] rhCount_t;

   ////////////////////////////////////////////////////////////////////////////
   // Transfer machine states
   ////////////////////////////////////////////////////////////////////////////

   // Idle means the controller is ready
   typedef enum logic
   {
      idle = 1'b0,
      busy = 1'b1
   } rhXferState_t;

   ////////////////////////////////////////////////////////////////////////////
   // Device register bit positions
   ////////////////////////////////////////////////////////////////////////////

   // GO bit in the CS1 low byte
   localparam int cs1GoBit = 0;

   // Low bit of the two BAE bits in the CS1 high byte
   localparam int cs1BaeLo = 8;

   // Bytes per word, added to BA on each acknowledge
   localparam int baStep = 2;

endpackage

`default_nettype wire

/* design/rhDevBus.sv */
////////////////////////////////////////////////////////////////////////////
// Device-bus writes into the RH11 registers
// Each strobe lasts one clock; lanes are levels valid with the strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface rhDevBus;
   import rhPkg::*;

   // Byte lane selects
   logic    loByte;
   logic    hiByte;

   // Write data
   rhData_t dataIn;

   // Register write strobes
   logic    cs1Write;
   logic    baWrite;
   logic    wcWrite;

   // Bus side, fed from the top-level pins
   modport host (output loByte, hiByte, dataIn, cs1Write, baWrite, wcWrite);

   // Register blocks only listen
   modport regs (input loByte, hiByte, dataIn, cs1Write, baWrite, wcWrite);

endinterface

`default_nettype wire

/* design/rhBusAddr.sv */
////////////////////////////////////////////////////////////////////////////
// RH11 Bus Address register, 18 bits with BAE from CS1
// A BA write in the same cycle as incBA wins and the increment is lost
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rhBusAddr
(
   input  logic         clk,
   input  logic         rst,
   input  logic         clr,
   rhDevBus.regs        bus,
   input  logic         rdy,
   input  logic         incBA,
   output rhPkg::rhAddr_t busAddr
);
   import rhPkg::*;

   // Extension bits may only change while idle
   logic baeLoad;

   // Byte lane loads of the low 16 bits
   logic hiLoad;
   logic loLoad;

   assign baeLoad = bus.cs1Write & bus.hiByte & rdy;
   assign hiLoad  = bus.baWrite & bus.hiByte;
   assign loLoad  = bus.baWrite & bus.loByte;

   ////////////////////////////////////////////////////////////////////////////
   // Address register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busAddr <= '0;
      end
      else if (clr)
      begin
         busAddr <= '0;
      end
      else
      begin
         // BAE from CS1 bits 9:8
         if (baeLoad)
            busAddr[17:16] <= bus.dataIn[cs1BaeLo +: 2];
         if (bus.baWrite)
         begin
            // Only the selected lanes change
            if (hiLoad)
               busAddr[15:8] <= bus.dataIn[15:8];
            if (loLoad)
               busAddr[7:0] <= bus.dataIn[7:0];
         end
         else if (incBA)
            // Full 18-bit add, carry runs into BAE
            busAddr <= busAddr + rhAddr_t'(baStep);
      end
   end

endmodule

`default_nettype wire

/* design/rhWordCount.sv */
////////////////////////////////////////////////////////////////////////////
// RH11 Word Count register, counts up from a negative load to zero
// wcLast is decoded from the register and is high when WC is all ones
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rhWordCount
(
   input  logic           clk,
   input  logic           rst,
   input  logic           clr,
   rhDevBus.regs          bus,
   input  logic           incWC,
   output rhPkg::rhCount_t wordCount,
   output logic           wcLast
);
   import rhPkg::*;

   // Lane loads
   logic hiLoad;
   logic loLoad;

   assign hiLoad = bus.wcWrite & bus.hiByte;
   assign loLoad = bus.wcWrite & bus.loByte;

   ////////////////////////////////////////////////////////////////////////////
   // Count register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wordCount <= '0;
      end
      else if (clr)
      begin
         wordCount <= '0;
      end
      else if (bus.wcWrite)
      begin
         // Write beats increment
         if (hiLoad)
            wordCount[15:8] <= bus.dataIn[15:8];
         if (loLoad)
            wordCount[7:0] <= bus.dataIn[7:0];
      end
      else if (incWC)
      begin
         wordCount <= wordCount + rhCount_t'(1);
      end
   end

   // Next acknowledge wraps the count to zero
   assign wcLast = (wordCount == '1);

endmodule

`default_nettype wire

/* design/rhXferCtrl.sv */
////////////////////////////////////////////////////////////////////////////
// RH11 transfer control, GO starts and the last-word acknowledge ends
// Acknowledges while idle are dropped; no other CS1 function is decoded
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rhXferCtrl
(
   input  logic  clk,
   input  logic  rst,
   input  logic  clr,
   rhDevBus.regs bus,
   input  logic  xferAck,
   input  logic  wcLast,
   output logic  rdy,
   output logic  xferReq,
   output logic  incBA,
   output logic  incWC
);
   import rhPkg::*;

   rhXferState_t state;
   rhXferState_t stateNext;

   // GO write decode
   logic goWrite;

   // Acknowledge seen during a transfer
   logic ackBusy;

   ////////////////////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////////////////////

   // Low byte holds GO
   assign goWrite = bus.cs1Write & bus.loByte & bus.dataIn[cs1GoBit];

   assign ackBusy = xferAck & (state == busy);

   ////////////////////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      stateNext = state;
      case (state)
         idle:
         begin
            // GO ignored unless ready, which idle implies
            if (goWrite)
               stateNext = busy;
         end
         busy:
         begin
            // Final word moved
            if (xferAck && wcLast)
               stateNext = idle;
         end
         default:
         begin
            stateNext = idle;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         state <= idle;
      else if (clr)
         state <= idle;
      else
         state <= stateNext;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////////////////////

   // Status straight from the state
   assign rdy     = (state == idle);
   assign xferReq = (state == busy);

   // Same-cycle strobes, registers step on this edge
   assign incBA = ackBusy;
   assign incWC = ackBusy;

endmodule

`default_nettype wire

/* design/rhTop.sv */
////////////////////////////////////////////////////////////////////////////
// RH11 transfer-address subsystem, BA and WC with the transfer control
// Registers are not read back; xferAck paces the transfer one word each
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rhTop
(
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  logic            loByte,
   input  logic            hiByte,
   input  rhPkg::rhData_t  dataIn,
   input  logic            cs1Write,
   input  logic            baWrite,
   input  logic            wcWrite,
   input  logic            xferAck,
   output rhPkg::rhAddr_t  busAddr,
   output rhPkg::rhCount_t wordCount,
   output logic            rdy,
   output logic            xferReq
);

   // Control to register strobes
   logic incBA;
   logic incWC;

   // Count status back to control
   logic wcLast;

   ////////////////////////////////////////////////////////////////////////////
   // Device bus
   ////////////////////////////////////////////////////////////////////////////

   rhDevBus devBus ();

   assign devBus.loByte   = loByte;
   assign devBus.hiByte   = hiByte;
   assign devBus.dataIn   = dataIn;
   assign devBus.cs1Write = cs1Write;
   assign devBus.baWrite  = baWrite;
   assign devBus.wcWrite  = wcWrite;

   ////////////////////////////////////////////////////////////////////////////
   // Register blocks and control
   ////////////////////////////////////////////////////////////////////////////

   rhBusAddr rhBusAddr_inst (.clk(clk), .rst(rst), .clr(clr), .bus(devBus.regs),
      .rdy(rdy), .incBA(incBA), .busAddr(busAddr));

   rhWordCount rhWordCount_inst (.clk(clk), .rst(rst), .clr(clr), .bus(devBus.regs),
      .incWC(incWC), .wordCount(wordCount), .wcLast(wcLast));

   rhXferCtrl rhXferCtrl_inst (.clk(clk), .rst(rst), .clr(clr), .bus(devBus.regs),
      .xferAck(xferAck), .wcLast(wcLast), .rdy(rdy), .xferReq(xferReq),
      .incBA(incBA), .incWC(incWC));

endmodule

`default_nettype wire

/* verif/rhTb.sv */
////////////////////////////////////////////////////////////////////////////
// Random register writes and transfers on rhTop against a reference model
// Inputs change on the falling edge, and all outputs are checked there too
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rhTb;
   import rhPkg::*;

   // Cycle budgets per test, summed for the watchdog
   localparam int resetBudget = 40;
   localparam int laneBudget  = 60;
   localparam int baeBudget   = 60;
   localparam int xferBudget  = 6 * (40 * 4 + 20);
   localparam int prioBudget  = 80;
   localparam int totalBudget = 3 + resetBudget + laneBudget + baeBudget + xferBudget
                                + prioBudget;

   logic     clk;
   logic     rst;
   logic     clr;
   logic     loByte;
   logic     hiByte;
   rhData_t  dataIn;
   logic     cs1Write;
   logic     baWrite;
   logic     wcWrite;
   logic     xferAck;
   rhAddr_t  busAddr;
   rhCount_t wordCount;
   logic     rdy;
   logic     xferReq;

   // Reference model state
   rhAddr_t  mBa;
   rhCount_t mWc;
   logic     mRdy;

   integer   seed;
   int       checksDone;
   int       errors;

   rhTop rhTop_inst (.clk(clk), .rst(rst), .clr(clr), .loByte(loByte), .hiByte(hiByte),
      .dataIn(dataIn), .cs1Write(cs1Write), .baWrite(baWrite), .wcWrite(wcWrite),
      .xferAck(xferAck), .busAddr(busAddr), .wordCount(wordCount), .rdy(rdy),
      .xferReq(xferReq));

   // 40 ns clock
   initial clk = 1'b0;
   always #20 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkAddr(input rhAddr_t got, input rhAddr_t exp, input string what);
      checksDone++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkCount(input rhCount_t got, input rhCount_t exp, input string what);
      checksDone++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      checksDone++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model, one rising edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic modelStep();
      rhAddr_t  nBa;
      rhCount_t nWc;
      logic     nRdy;
      logic     inc;
      nBa  = mBa;
      nWc  = mWc;
      nRdy = mRdy;
      // Acks only count during a transfer
      inc  = xferAck && !mRdy;
      if (clr)
      begin
         nBa  = '0;
         nWc  = '0;
         nRdy = 1'b1;
      end
      else
      begin
         // BAE takes CS1 high byte only while ready
         if (cs1Write && hiByte && mRdy)
            nBa[17:16] = dataIn[cs1BaeLo +: 2];
         if (baWrite)
         begin
            if (hiByte)
               nBa[15:8] = dataIn[15:8];
            if (loByte)
               nBa[7:0] = dataIn[7:0];
         end
         else if (inc)
            nBa = mBa + rhAddr_t'(baStep);
         if (wcWrite)
         begin
            if (hiByte)
               nWc[15:8] = dataIn[15:8];
            if (loByte)
               nWc[7:0] = dataIn[7:0];
         end
         else if (inc)
            nWc = mWc + rhCount_t'(1);
         // GO starts and an ack on count -1 ends
         if (mRdy && cs1Write && loByte && dataIn[cs1GoBit])
            nRdy = 1'b0;
         else if (inc && mWc == 16'hffff)
            nRdy = 1'b1;
      end
      mBa  = nBa;
      mWc  = nWc;
      mRdy = nRdy;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // Drive one cycle from a falling edge and check at the next one
   task automatic runCycle(input logic lo, input logic hi, input rhData_t data,
      input logic cs1, input logic ba, input logic wc, input logic ack, input logic cl);
      loByte   = lo;
      hiByte   = hi;
      dataIn   = data;
      cs1Write = cs1;
      baWrite  = ba;
      wcWrite  = wc;
      xferAck  = ack;
      clr      = cl;
      @(posedge clk);
      modelStep();
      @(negedge clk);
      checkAddr(busAddr, mBa, "BA");
      checkCount(wordCount, mWc, "WC");
      checkFlag(rdy, mRdy, "rdy");
      checkFlag(xferReq, ~mRdy, "xferReq");
      loByte   = 1'b0;
      hiByte   = 1'b0;
      dataIn   = '0;
      cs1Write = 1'b0;
      baWrite  = 1'b0;
      wcWrite  = 1'b0;
      xferAck  = 1'b0;
      clr      = 1'b0;
   endtask

   task automatic idleCycles(input int n);
      repeat (n) runCycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic loadAddr(input logic lo, input logic hi, input rhData_t d);
      runCycle(lo, hi, d, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic loadCount(input logic lo, input logic hi, input rhData_t d);
      runCycle(lo, hi, d, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
   endtask

   task automatic strobeCs1(input logic lo, input logic hi, input rhData_t d);
      runCycle(lo, hi, d, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic pulseAck();
      runCycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
   endtask

   function automatic rhData_t randomData();
      return rhData_t'({$random(seed), $random(seed)});
   endfunction

   // Ack with random gaps until rdy rises
   task automatic drainXfer(output int acks);
      int gap;
      acks = 0;
      while (rdy !== 1'b1)
      begin
         gap = $unsigned($random(seed)) % 4;
         idleCycles(gap);
         pulseAck();
         acks++;
      end
   endtask

   task automatic reportTest(input string name, input int errStart);
      if (errors == errStart)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - errStart);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      int         n;
      int         words;
      int         acks;
      int         errStart;
      rhAddr_t    startBa;
      rhAddr_t    heldBa;
      rhData_t    d;
      logic [1:0] bae;
      logic [1:0] lanes;
      seed       = 32'h7d05_efd5;
      checksDone = 0;
      errors     = 0;
      rst        = 1'b1;
      clr        = 1'b0;
      loByte     = 1'b0;
      hiByte     = 1'b0;
      dataIn     = '0;
      cs1Write   = 1'b0;
      baWrite    = 1'b0;
      wcWrite    = 1'b0;
      xferAck    = 1'b0;
      mBa        = '0;
      mWc        = '0;
      mRdy       = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset values and a clr at a random point mid transfer
      errStart = errors;
      checkAddr(busAddr, '0, "BA after reset");
      checkCount(wordCount, '0, "WC after reset");
      checkFlag(rdy, 1'b1, "rdy after reset");
      checkFlag(xferReq, 1'b0, "xferReq after reset");
      // At least GO, one BA load and one WC load before clr
      n = 3 + $unsigned($random(seed)) % 6;
      for (int i = 0; i < n; i++)
      begin
         if (i == 0)
            strobeCs1(1'b1, 1'b1, randomData() | rhData_t'(1));
         else if (i % 2 == 1)
            loadAddr(1'b1, 1'b1, randomData());
         else
            loadCount(1'b1, 1'b1, randomData());
      end
      runCycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
      checkAddr(busAddr, '0, "BA after clr");
      checkCount(wordCount, '0, "WC after clr");
      checkFlag(rdy, 1'b1, "rdy after clr");
      checkFlag(xferReq, 1'b0, "xferReq after clr");
      reportTest("Test 1 reset and clear", errStart);

      // Random lanes into BA and WC
      errStart = errors;
      for (int i = 0; i < 40; i++)
      begin
         lanes = 2'($unsigned($random(seed)));
         d = randomData();
         if ($random(seed) & 1)
            loadAddr(lanes[0], lanes[1], d);
         else
            loadCount(lanes[0], lanes[1], d);
      end
      reportTest("Test 2 byte lanes", errStart);

      // BAE loads while ready and holds while busy
      errStart = errors;
      // Nonzero so the load differs from the cleared BAE
      bae = 2'(1 + $unsigned($random(seed)) % 3);
      strobeCs1(1'b0, 1'b1, rhData_t'(bae) << cs1BaeLo);
      checkAddr(rhAddr_t'(busAddr[17:16]), rhAddr_t'(bae), "BAE load while ready");
      loadCount(1'b1, 1'b1, rhData_t'(16'hfffe));
      strobeCs1(1'b1, 1'b0, rhData_t'(1) << cs1GoBit);
      heldBa = busAddr;
      strobeCs1(1'b0, 1'b1, rhData_t'(~bae) << cs1BaeLo);
      checkAddr(busAddr, heldBa, "BAE held while busy");
      drainXfer(acks);
      reportTest("Test 3 extension bits", errStart);

      // Full transfers; first two cross into and out of BAE
      errStart = errors;
      for (int t = 0; t < 6; t++)
      begin
         words   = 1 + $unsigned($random(seed)) % 40;
         startBa = rhAddr_t'($random(seed));
         if (t == 0)
         begin
            words = 20;
            startBa[15:0] = 16'hffe0;
         end
         else if (t == 1)
         begin
            words = 10;
            startBa = 18'h3fff8;
         end
         loadAddr(1'b1, 1'b1, rhData_t'(startBa[15:0]));
         strobeCs1(1'b0, 1'b1, rhData_t'(startBa[17:16]) << cs1BaeLo);
         loadCount(1'b1, 1'b1, rhData_t'(rhCount_t'(-words)));
         // Idle ack must do nothing
         pulseAck();
         strobeCs1(1'b1, 1'b0, rhData_t'(1) << cs1GoBit);
         checkFlag(xferReq, 1'b1, "xferReq after GO");
         drainXfer(acks);
         checkCount(rhCount_t'(acks), rhCount_t'(words), "acks until rdy");
         checkAddr(busAddr, rhAddr_t'(startBa + baStep * words), "BA after transfer");
         checkCount(wordCount, '0, "WC after transfer");
         pulseAck();
      end
      reportTest("Test 4 full transfer", errStart);

      // Register write wins over a same-cycle ack
      errStart = errors;
      loadCount(1'b1, 1'b1, rhData_t'(16'hfffb));
      loadAddr(1'b1, 1'b1, randomData());
      strobeCs1(1'b1, 1'b0, rhData_t'(1) << cs1GoBit);
      pulseAck();
      d = randomData();
      heldBa = busAddr;
      runCycle(1'b1, 1'b1, d, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
      checkAddr(busAddr, {heldBa[17:16], d[15:0]}, "BA write beats ack");
      runCycle(1'b1, 1'b1, rhData_t'(16'hfffd), 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
      checkCount(wordCount, 16'hfffd, "WC write beats ack");
      drainXfer(acks);
      checkCount(rhCount_t'(acks), rhCount_t'(3), "acks after WC rewrite");
      reportTest("Test 5 priority", errStart);

      $display("Checks: %0d, errors: %0d", checksDone, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(totalBudget * 40 + 1000);
      $display("Timeout: run went past its budget of %0d clock cycles", totalBudget);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
design/rhPkg.sv
design/rhDevBus.sv
design/rhBusAddr.sv
design/rhWordCount.sv
design/rhXferCtrl.sv
design/rhTop.sv
verif/rhTb.sv

/* Makefile */
# Verilator flow for the RH11 transfer-address subsystem

SIM       := verilator
TOP       := rhTb
FILELIST  := src.f
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir
LOG       := sim.log
PASSMSG   := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
